// ==== hw/lsu_consts.svh ====
////////////////////////////////////////
// LSU constants
// Data width, memory depth, fault codes
// and the reset window of the region
// registers
////////////////////////////////////////

`ifndef LSU_CONSTS_SVH
`define LSU_CONSTS_SVH

// Data and address width
`define LSU_XLEN 32

// Data memory depth in words
`define LSU_DMEM_WORDS 256

// Fault codes reported on lsu_fault
`define LSU_FAULT_NONE       2'd0
`define LSU_FAULT_MISALIGNED 2'd1
`define LSU_FAULT_ACCESS     2'd2

// Region window after reset
`define LSU_REGION_BASE_RST  32'h0000_0000
`define LSU_REGION_LIMIT_RST 32'h0000_03FF

`endif

// ==== hw/lsu_pkg.sv ====
////////////////////////////////////////
// LSU package
// Opcode and funct3 encodings, the
// instruction union and the load tag
////////////////////////////////////////

`default_nettype none

`include "lsu_consts.svh"

package lsu_pkg;

  // Major opcode, instruction bits 6:2
  typedef enum logic [4:0] {
    OPC_LOAD  = 5'b00000,
    OPC_STORE = 5'b01000
  } opcode_e;

  // funct3 of loads and stores
  typedef enum logic [2:0] {
    MS_B  = 3'b000,
    MS_H  = 3'b001,
    MS_W  = 3'b010,
    MS_BU = 3'b100,
    MS_HU = 3'b101
  } mem_size_e;

  // I-type layout, used by loads
  typedef struct packed {
    logic [11:0] imm;
    logic [4:0]  rs1;
    mem_size_e   funct3;
    logic [4:0]  rd;
    opcode_e     opcode;
    logic [1:0]  quad;
  } instr_i_s;

  // S-type layout, used by stores
  typedef struct packed {
    logic [6:0] imm_hi;
    logic [4:0] rs2;
    logic [4:0] rs1;
    mem_size_e  funct3;
    logic [4:0] imm_lo;
    opcode_e    opcode;
    logic [1:0] quad;
  } instr_s_s;

  // Same word seen as load or store
  typedef union packed {
    instr_i_s i;
    instr_s_s s;
  } instr_u;

  typedef enum logic [1:0] {
    FAULT_NONE       = `LSU_FAULT_NONE,
    FAULT_MISALIGNED = `LSU_FAULT_MISALIGNED,
    FAULT_ACCESS     = `LSU_FAULT_ACCESS
  } fault_e;

  // Request to aligner
  typedef struct packed {
    mem_size_e  size;
    logic [1:0] offset;
    logic       sign_ext;
  } load_tag_s;

endpackage

`default_nettype wire

// ==== hw/lsu_region_regs.sv ====
////////////////////////////////////////
// LSU region registers
// One protection window (base, limit,
// enable) written by a config strobe
////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "lsu_consts.svh"

module lsu_region_regs (
  input  wire logic                 clk,
  input  wire logic                 rstn,
  input  wire logic                 cfg_we,
  input  wire logic [1:0]           cfg_addr,
  input  wire logic [`LSU_XLEN-1:0] cfg_wdata,
  output logic      [`LSU_XLEN-1:0] region_base,
  output logic      [`LSU_XLEN-1:0] region_limit,
  output logic                      region_en
);

  // Register map
  // 0 base, 1 limit, 2 enable in bit 0
  always_ff @(posedge clk or negedge rstn)
  begin
    if (!rstn)
    begin
      region_base  <= `LSU_REGION_BASE_RST;
      region_limit <= `LSU_REGION_LIMIT_RST;
      region_en    <= 1'b1;
    end
    else if (cfg_we)
    begin
      case (cfg_addr)
        // Word granular bounds
        2'd0: region_base  <= {cfg_wdata[`LSU_XLEN-1:2], 2'b00};
        2'd1: region_limit <= {cfg_wdata[`LSU_XLEN-1:2], 2'b00};
        2'd2: region_en    <= cfg_wdata[0];
        // Address 3 not mapped
        default: ;
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== hw/lsu_request.sv ====
////////////////////////////////////////
// LSU request stage
// Decodes loads and stores, forms the
// address, byte enables and store data,
// checks alignment and the region window
// and issues one memory request per slot
////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "lsu_consts.svh"

module lsu_request (
  input  wire logic                   clk,
  input  wire logic                   rstn,
  input  wire logic                   ex_stall,
  input  wire logic                   id_bubble,
  input  wire lsu_pkg::instr_u        id_instr,
  input  wire logic [`LSU_XLEN-1:0]   id_exception,
  input  wire logic [`LSU_XLEN-1:0]   op_a,
  input  wire logic [`LSU_XLEN-1:0]   op_b,
  input  wire logic [`LSU_XLEN-1:0]   region_base,
  input  wire logic [`LSU_XLEN-1:0]   region_limit,
  input  wire logic                   region_en,
  output logic                        lsu_bubble,
  output logic      [`LSU_XLEN-1:0]   lsu_exception,
  output lsu_pkg::fault_e             lsu_fault,
  output logic                        dmem_req,
  output logic                        dmem_we,
  output logic      [`LSU_XLEN/8-1:0] dmem_be,
  output logic      [`LSU_XLEN-1:0]   dmem_adr,
  output logic      [`LSU_XLEN-1:0]   dmem_d,
  output lsu_pkg::load_tag_s          load_tag
);

  import lsu_pkg::*;

  logic                   is_load;
  logic                   is_store;
  logic                   accept;
  mem_size_e              size;
  logic [`LSU_XLEN-1:0]   imm_i;
  logic [`LSU_XLEN-1:0]   imm_s;
  logic [`LSU_XLEN-1:0]   adr;
  logic [4:0]             lane_shift;
  logic [`LSU_XLEN/8-1:0] be;
  logic [`LSU_XLEN-1:0]   d;
  logic                   misaligned;
  logic                   out_of_window;
  fault_e                 fault_nxt;

  ////////////////////////////////////////
  // Decode
  ////////////////////////////////////////

  // Opcode and quadrant sit in the same bits for both layouts
  assign is_load  = (id_instr.i.opcode == OPC_LOAD) && (id_instr.i.quad == 2'b11);
  assign is_store = (id_instr.s.opcode == OPC_STORE) && (id_instr.s.quad == 2'b11);

  // Width field shared by both layouts
  assign size = id_instr.i.funct3;

  // Sign extended immediates
  assign imm_i = {{(`LSU_XLEN-12){id_instr.i.imm[11]}}, id_instr.i.imm};
  assign imm_s = {{(`LSU_XLEN-12){id_instr.s.imm_hi[6]}},
                  id_instr.s.imm_hi, id_instr.s.imm_lo};

  // Valid memory slot
  assign accept = !ex_stall && !id_bubble && (id_exception == '0) && (is_load || is_store);

  ////////////////////////////////////////
  // Address, enables, store data
  ////////////////////////////////////////

  assign adr        = op_a + (is_store ? imm_s : imm_i);
  assign lane_shift = {adr[1:0], 3'b000};

  always_comb
  begin
    case (size)
      MS_B, MS_BU:
      begin
        be         = 4'b0001 << adr[1:0];
        d          = {24'h0, op_b[7:0]} << lane_shift;
        misaligned = 1'b0;
      end
      MS_H, MS_HU:
      begin
        be         = 4'b0011 << adr[1:0];
        d          = {16'h0, op_b[15:0]} << lane_shift;
        misaligned = adr[0];
      end
      default:
      begin
        // Word access
        be         = 4'b1111;
        d          = op_b;
        misaligned = |adr[1:0];
      end
    endcase
  end

  // Inclusive window check
  assign out_of_window = region_en && ((adr < region_base) || (adr > region_limit));

  // Misalignment wins over window fault
  always_comb
  begin
    if (misaligned)
      fault_nxt = FAULT_MISALIGNED;
    else if (out_of_window)
      fault_nxt = FAULT_ACCESS;
    else
      fault_nxt = FAULT_NONE;
  end

  ////////////////////////////////////////
  // Issue stage
  ////////////////////////////////////////

  always_ff @(posedge clk or negedge rstn)
  begin
    if (!rstn)
    begin
      lsu_bubble <= 1'b1;
      lsu_fault  <= FAULT_NONE;
      dmem_req   <= 1'b0;
    end
    else
    begin
      lsu_bubble <= !accept;
      lsu_fault  <= accept ? fault_nxt : FAULT_NONE;
      // Faulting access never reaches memory
      dmem_req   <= accept && (fault_nxt == FAULT_NONE);
    end
  end

  // Request payload and tag
  always_ff @(posedge clk)
  begin
    if (accept)
    begin
      dmem_we           <= is_store;
      dmem_be           <= be;
      dmem_adr          <= adr;
      dmem_d            <= d;
      load_tag.size     <= size;
      load_tag.offset   <= adr[1:0];
      load_tag.sign_ext <= (size == MS_B) || (size == MS_H);
    end
  end

  // Exception code follows the slot when not stalled
  always_ff @(posedge clk or negedge rstn)
  begin
    if (!rstn)
      lsu_exception <= '0;
    else if (!ex_stall)
      lsu_exception <= id_exception;
  end

endmodule

`default_nettype wire

// ==== hw/lsu_dmem.sv ====
////////////////////////////////////////
// LSU data memory
// Byte enabled synchronous RAM that
// acks every request one cycle later
////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "lsu_consts.svh"

module lsu_dmem (
  input  wire logic                   clk,
  input  wire logic                   rstn,
  input  wire logic                   dmem_req,
  input  wire logic                   dmem_we,
  input  wire logic [`LSU_XLEN/8-1:0] dmem_be,
  input  wire logic [`LSU_XLEN-1:0]   dmem_adr,
  input  wire logic [`LSU_XLEN-1:0]   dmem_d,
  output logic                        dmem_ack,
  output logic      [`LSU_XLEN-1:0]   dmem_q
);

  localparam int AW = $clog2(`LSU_DMEM_WORDS);

  logic [`LSU_XLEN-1:0] mem [`LSU_DMEM_WORDS];
  logic [AW-1:0]        idx;

  // Word index, upper address bits wrap
  assign idx = dmem_adr[AW+1:2];

  // Contents start cleared
  initial
  begin
    for (int i = 0; i < `LSU_DMEM_WORDS; i++)
      mem[i] = '0;
  end

  ////////////////////////////////////////
  // Array access
  ////////////////////////////////////////

  always_ff @(posedge clk)
  begin
    if (dmem_req)
    begin
      // Read returns the word before any write
      dmem_q <= mem[idx];
      if (dmem_we)
      begin
        for (int b = 0; b < `LSU_XLEN/8; b++)
        begin
          if (dmem_be[b])
            mem[idx][8*b +: 8] <= dmem_d[8*b +: 8];
        end
      end
    end
  end

  // Fixed one cycle latency
  always_ff @(posedge clk or negedge rstn)
  begin
    if (!rstn)
      dmem_ack <= 1'b0;
    else
      dmem_ack <= dmem_req;
  end

endmodule

`default_nettype wire

// ==== hw/lsu_load_align.sv ====
////////////////////////////////////////
// LSU load aligner
// Lines the tag up with the memory ack,
// then shifts and extends load data
////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "lsu_consts.svh"

module lsu_load_align (
  input  wire logic                 clk,
  input  wire logic                 rstn,
  input  wire lsu_pkg::load_tag_s   load_tag,
  input  wire logic                 dmem_req,
  input  wire logic                 dmem_we,
  input  wire logic                 dmem_ack,
  input  wire logic [`LSU_XLEN-1:0] dmem_q,
  output logic                      load_valid,
  output logic      [`LSU_XLEN-1:0] load_data
);

  import lsu_pkg::*;

  load_tag_s            tag_q;
  logic                 pend_load;
  logic [`LSU_XLEN-1:0] shifted;
  logic [`LSU_XLEN-1:0] ext;

  ////////////////////////////////////////
  // Tag stage
  ////////////////////////////////////////

  // Advances every cycle, one request per slot
  always_ff @(posedge clk)
  begin
    tag_q <= load_tag;
  end

  // Request in flight is a load
  always_ff @(posedge clk or negedge rstn)
  begin
    if (!rstn)
      pend_load <= 1'b0;
    else
      pend_load <= dmem_req && !dmem_we;
  end

  ////////////////////////////////////////
  // Extract and extend
  ////////////////////////////////////////

  // Selected lane down to bit 0
  assign shifted = dmem_q >> {tag_q.offset, 3'b000};

  always_comb
  begin
    case (tag_q.size)
      MS_B, MS_BU:
        ext = {{(`LSU_XLEN-8){tag_q.sign_ext & shifted[7]}}, shifted[7:0]};
      MS_H, MS_HU:
        ext = {{(`LSU_XLEN-16){tag_q.sign_ext & shifted[15]}}, shifted[15:0]};
      default:
        ext = shifted;
    endcase
  end

  // Result stage
  always_ff @(posedge clk or negedge rstn)
  begin
    if (!rstn)
      load_valid <= 1'b0;
    else
      load_valid <= dmem_ack && pend_load;
  end

  always_ff @(posedge clk)
  begin
    if (dmem_ack && pend_load)
      load_data <= ext;
  end

endmodule

`default_nettype wire

// ==== hw/lsu_top.sv ====
////////////////////////////////////////
// LSU top
// Region registers, request stage, data
// memory and load aligner
////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "lsu_consts.svh"

module lsu_top (
  input  wire logic                 clk,
  input  wire logic                 rstn,
  input  wire logic                 ex_stall,
  input  wire logic                 id_bubble,
  input  wire lsu_pkg::instr_u      id_instr,
  input  wire logic [`LSU_XLEN-1:0] id_exception,
  input  wire logic [`LSU_XLEN-1:0] op_a,
  input  wire logic [`LSU_XLEN-1:0] op_b,
  input  wire logic                 cfg_we,
  input  wire logic [1:0]           cfg_addr,
  input  wire logic [`LSU_XLEN-1:0] cfg_wdata,
  output logic                      lsu_bubble,
  output logic      [`LSU_XLEN-1:0] lsu_exception,
  output lsu_pkg::fault_e           lsu_fault,
  output logic                      load_valid,
  output logic      [`LSU_XLEN-1:0] load_data
);

  import lsu_pkg::*;

  // Window
  logic [`LSU_XLEN-1:0]   region_base;
  logic [`LSU_XLEN-1:0]   region_limit;
  logic                   region_en;

  // Memory bus
  logic                   dmem_req;
  logic                   dmem_we;
  logic [`LSU_XLEN/8-1:0] dmem_be;
  logic [`LSU_XLEN-1:0]   dmem_adr;
  logic [`LSU_XLEN-1:0]   dmem_d;
  logic                   dmem_ack;
  logic [`LSU_XLEN-1:0]   dmem_q;

  load_tag_s              load_tag;

  lsu_region_regs u_region_regs (
    .clk          (clk),
    .rstn         (rstn),
    .cfg_we       (cfg_we),
    .cfg_addr     (cfg_addr),
    .cfg_wdata    (cfg_wdata),
    .region_base  (region_base),
    .region_limit (region_limit),
    .region_en    (region_en)
  );

  lsu_request u_request (
    .clk           (clk),
    .rstn          (rstn),
    .ex_stall      (ex_stall),
    .id_bubble     (id_bubble),
    .id_instr      (id_instr),
    .id_exception  (id_exception),
    .op_a          (op_a),
    .op_b          (op_b),
    .region_base   (region_base),
    .region_limit  (region_limit),
    .region_en     (region_en),
    .lsu_bubble    (lsu_bubble),
    .lsu_exception (lsu_exception),
    .lsu_fault     (lsu_fault),
    .dmem_req      (dmem_req),
    .dmem_we       (dmem_we),
    .dmem_be       (dmem_be),
    .dmem_adr      (dmem_adr),
    .dmem_d        (dmem_d),
    .load_tag      (load_tag)
  );

  lsu_dmem u_dmem (
    .clk      (clk),
    .rstn     (rstn),
    .dmem_req (dmem_req),
    .dmem_we  (dmem_we),
    .dmem_be  (dmem_be),
    .dmem_adr (dmem_adr),
    .dmem_d   (dmem_d),
    .dmem_ack (dmem_ack),
    .dmem_q   (dmem_q)
  );

  lsu_load_align u_load_align (
    .clk        (clk),
    .rstn       (rstn),
    .load_tag   (load_tag),
    .dmem_req   (dmem_req),
    .dmem_we    (dmem_we),
    .dmem_ack   (dmem_ack),
    .dmem_q     (dmem_q),
    .load_valid (load_valid),
    .load_data  (load_data)
  );

endmodule

`default_nettype wire

// ==== verification/lsu_tb.sv ====
////////////////////////////////////////
// LSU testbench
// Random loads, stores and config writes
// checked cycle by cycle against a model
// with a byte mirror of the memory
////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "lsu_consts.svh"

module lsu_tb;

  import lsu_pkg::*;

  localparam int CLK_NS    = 4;
  localparam int RESET_CYC = 8;
  localparam int DRAIN     = 4;
  localparam int N_ZERO    = 8;
  localparam int N_STORE   = 24;
  localparam int N_LOAD    = 24;
  localparam int N_B2B     = 32;
  localparam int N_MIS     = 24;
  localparam int N_SUP     = 40;
  localparam int N_REG     = 24;
  localparam int TOTAL_OPS = N_ZERO + N_STORE + N_LOAD + N_B2B + N_MIS + N_SUP + N_REG;
  // At most six slots per operation, six tests with a drain each
  localparam int WATCH_NS  = (6 * TOTAL_OPS + RESET_CYC + 6 * DRAIN) * CLK_NS + 400;

  localparam logic [6:0] OPC7_LOAD  = 7'b0000011;
  localparam logic [6:0] OPC7_STORE = 7'b0100011;
  localparam logic [6:0] OPC7_ALU   = 7'b0110011;

  // DUT ports
  logic        clk;
  logic        rstn;
  logic        ex_stall;
  logic        id_bubble;
  instr_u      id_instr;
  logic [31:0] id_exception;
  logic [31:0] op_a;
  logic [31:0] op_b;
  logic        cfg_we;
  logic [1:0]  cfg_addr;
  logic [31:0] cfg_wdata;
  logic        lsu_bubble;
  logic [31:0] lsu_exception;
  fault_e      lsu_fault;
  logic        load_valid;
  logic [31:0] load_data;

  // Slot for the next falling edge
  logic        n_stall;
  logic        n_bubble;
  logic [31:0] n_instr;
  logic [31:0] n_exc;
  logic [31:0] n_a;
  logic [31:0] n_b;
  logic [31:0] n_off;
  mem_size_e   n_size;
  logic        n_cfg_we;
  logic [1:0]  n_cfg_addr;
  logic [31:0] n_cfg_wdata;

  // Reference model
  logic [7:0]  mirror [4*`LSU_DMEM_WORDS];
  logic [31:0] m_base;
  logic [31:0] m_limit;
  logic        m_en;
  logic        exp_bubble;
  fault_e      exp_fault;
  logic [31:0] exp_exc;
  logic [31:0] exp_q [$];
  int          due_q [$];

  int          cyc;
  int          checks;
  int          errors;
  int          t_checks;
  int          t_errors;

  lsu_top u_dut (
    .clk           (clk),
    .rstn          (rstn),
    .ex_stall      (ex_stall),
    .id_bubble     (id_bubble),
    .id_instr      (id_instr),
    .id_exception  (id_exception),
    .op_a          (op_a),
    .op_b          (op_b),
    .cfg_we        (cfg_we),
    .cfg_addr      (cfg_addr),
    .cfg_wdata     (cfg_wdata),
    .lsu_bubble    (lsu_bubble),
    .lsu_exception (lsu_exception),
    .lsu_fault     (lsu_fault),
    .load_valid    (load_valid),
    .load_data     (load_data)
  );

  initial
  begin
    clk = 1'b0;
    forever #(CLK_NS / 2) clk = ~clk;
  end

  always @(posedge clk)
    cyc <= cyc + 1;

  // Watchdog
  initial
  begin
    #(WATCH_NS);
    $display("Timeout: the run did not finish within %0d ns", WATCH_NS);
    $display("Testbench failed");
    $finish;
  end

  ////////////////////////////////////////
  // Compare tasks
  ////////////////////////////////////////

  task automatic check_load(input logic [31:0] got, input logic [31:0] exp);
    checks++;
    if (got !== exp)
    begin
      errors++;
      $display("[ERROR] %0t: load_data got %h expected %h", $time, got, exp);
    end
  endtask

  task automatic check_fault(input fault_e got, input fault_e exp);
    checks++;
    if (got !== exp)
    begin
      errors++;
      $display("[ERROR] %0t: lsu_fault got %0d expected %s", $time, got, exp.name());
    end
  endtask

  task automatic check_exception(input logic [31:0] got, input logic [31:0] exp);
    checks++;
    if (got !== exp)
    begin
      errors++;
      $display("[ERROR] %0t: lsu_exception got %h expected %h", $time, got, exp);
    end
  endtask

  task automatic check_bubble(input logic got, input logic exp);
    checks++;
    if (got !== exp)
    begin
      errors++;
      $display("[ERROR] %0t: lsu_bubble got %b expected %b", $time, got, exp);
    end
  endtask

  ////////////////////////////////////////
  // Model helpers
  ////////////////////////////////////////

  function automatic fault_e access_fault(input logic [31:0] addr, input mem_size_e sz);
    logic mis;
    case (sz)
      MS_H, MS_HU: mis = addr[0];
      MS_W:        mis = (addr[1:0] != 2'b00);
      default:     mis = 1'b0;
    endcase
    if (mis)
      return FAULT_MISALIGNED;
    if (m_en && ((addr < m_base) || (addr > m_limit)))
      return FAULT_ACCESS;
    return FAULT_NONE;
  endfunction

  // Memory wraps at 1 KiB
  function automatic logic [31:0] load_value(input logic [31:0] addr, input mem_size_e sz);
    logic [9:0]  idx;
    logic [31:0] w;
    idx = addr[9:0];
    w = {mirror[idx + 10'd3], mirror[idx + 10'd2], mirror[idx + 10'd1], mirror[idx]};
    case (sz)
      MS_B:    return {{24{w[7]}}, w[7:0]};
      MS_BU:   return {24'h0, w[7:0]};
      MS_H:    return {{16{w[15]}}, w[15:0]};
      MS_HU:   return {16'h0, w[15:0]};
      default: return w;
    endcase
  endfunction

  task automatic mirror_store(input logic [31:0] addr, input mem_size_e sz,
                              input logic [31:0] data);
    logic [9:0] idx;
    int         n;
    idx = addr[9:0];
    n = (sz == MS_W) ? 4 : ((sz == MS_H) ? 2 : 1);
    for (int k = 0; k < n; k++)
      mirror[idx + 10'(k)] = data[8*k +: 8];
  endtask

  function automatic logic [31:0] align_addr(input logic [31:0] addr, input mem_size_e sz);
    case (sz)
      MS_H, MS_HU: return {addr[31:1], 1'b0};
      MS_W:        return {addr[31:2], 2'b00};
      default:     return addr;
    endcase
  endfunction

  function automatic mem_size_e pick_load_size();
    case ($urandom_range(0, 4))
      0:       return MS_B;
      1:       return MS_H;
      2:       return MS_W;
      3:       return MS_BU;
      default: return MS_HU;
    endcase
  endfunction

  function automatic mem_size_e pick_store_size();
    case ($urandom_range(0, 2))
      0:       return MS_B;
      1:       return MS_H;
      default: return MS_W;
    endcase
  endfunction

  ////////////////////////////////////////
  // Slot builders and the cycle step
  ////////////////////////////////////////

  task automatic set_idle();
    n_stall     = 1'b0;
    n_bubble    = 1'b1;
    n_instr     = $urandom;
    n_exc       = 32'd0;
    n_a         = $urandom;
    n_b         = $urandom;
    n_off       = 32'd0;
    n_size      = MS_W;
    n_cfg_we    = 1'b0;
    n_cfg_addr  = 2'd0;
    n_cfg_wdata = 32'd0;
  endtask

  // Random immediate in -64..63, op_a makes up the rest
  task automatic set_load(input mem_size_e sz, input logic [31:0] addr);
    logic [11:0] imm;
    imm      = 12'($urandom_range(0, 127)) - 12'd64;
    n_off    = {{20{imm[11]}}, imm};
    n_a      = addr - n_off;
    n_size   = sz;
    n_bubble = 1'b0;
    n_instr  = {imm, 5'($urandom), sz, 5'($urandom), OPC7_LOAD};
  endtask

  task automatic set_store(input mem_size_e sz, input logic [31:0] addr,
                           input logic [31:0] data);
    logic [11:0] imm;
    imm      = 12'($urandom_range(0, 127)) - 12'd64;
    n_off    = {{20{imm[11]}}, imm};
    n_a      = addr - n_off;
    n_b      = data;
    n_size   = sz;
    n_bubble = 1'b0;
    n_instr  = {imm[11:5], 5'($urandom), 5'($urandom), sz, imm[4:0], OPC7_STORE};
  endtask

  task automatic set_cfg(input logic [1:0] addr, input logic [31:0] data);
    n_cfg_we    = 1'b1;
    n_cfg_addr  = addr;
    n_cfg_wdata = data;
  endtask

  task automatic apply_inputs();
    ex_stall     = n_stall;
    id_bubble    = n_bubble;
    id_instr     = n_instr;
    id_exception = n_exc;
    op_a         = n_a;
    op_b         = n_b;
    cfg_we       = n_cfg_we;
    cfg_addr     = n_cfg_addr;
    cfg_wdata    = n_cfg_wdata;
  endtask

  // Outputs of the last edge against the model
  task automatic check_outputs();
    int          due;
    logic [31:0] exp_d;
    check_bubble(lsu_bubble, exp_bubble);
    check_fault(lsu_fault, exp_fault);
    check_exception(lsu_exception, exp_exc);
    if (load_valid)
    begin
      if (due_q.size() == 0)
      begin
        errors++;
        $display("Load result at %0t arrived with no load outstanding", $time);
      end
      else
      begin
        due   = due_q.pop_front();
        exp_d = exp_q.pop_front();
        if (due != cyc)
        begin
          errors++;
          $display("Load result arrived in cycle %0d but was due in cycle %0d", cyc, due);
        end
        check_load(load_data, exp_d);
      end
    end
    else if ((due_q.size() > 0) && (due_q[0] <= cyc))
    begin
      errors++;
      $display("Load result due in cycle %0d never arrived", due_q.pop_front());
      exp_d = exp_q.pop_front();
    end
  endtask

  task automatic step();
    logic [31:0] addr;
    logic        is_ld;
    logic        is_st;
    logic        acc;
    fault_e      f;
    @(negedge clk);
    check_outputs();
    apply_inputs();
    // Model of the coming edge
    if (!n_stall)
      exp_exc = n_exc;
    is_ld = (n_instr[6:0] == OPC7_LOAD);
    is_st = (n_instr[6:0] == OPC7_STORE);
    acc   = !n_stall && !n_bubble && (n_exc == 32'd0) && (is_ld || is_st);
    addr  = n_a + n_off;
    f     = acc ? access_fault(addr, n_size) : FAULT_NONE;
    exp_bubble = !acc;
    exp_fault  = f;
    if (acc && (f == FAULT_NONE))
    begin
      if (is_st)
        mirror_store(addr, n_size, n_b);
      else
      begin
        // Valid after the second edge past acceptance
        exp_q.push_back(load_value(addr, n_size));
        due_q.push_back(cyc + 3);
      end
    end
    // Window writes land at the same edge
    if (n_cfg_we)
    begin
      case (n_cfg_addr)
        2'd0:    m_base  = {n_cfg_wdata[31:2], 2'b00};
        2'd1:    m_limit = {n_cfg_wdata[31:2], 2'b00};
        2'd2:    m_en    = n_cfg_wdata[0];
        default: ;
      endcase
    end
    set_idle();
  endtask

  task automatic report_test(input string name);
    repeat (DRAIN) step();
    $display("Test %-12s checks %0d errors %0d", name, checks - t_checks, errors - t_errors);
    t_checks = checks;
    t_errors = errors;
  endtask

  ////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////

  initial
  begin
    mem_size_e   sz;
    logic [31:0] base;
    logic [31:0] addr;
    void'($urandom(32'h8353));
    cyc = 0;
    checks = 0;
    errors = 0;
    t_checks = 0;
    t_errors = 0;
    for (int i = 0; i < 4 * `LSU_DMEM_WORDS; i++)
      mirror[i] = 8'h00;
    m_base     = `LSU_REGION_BASE_RST;
    m_limit    = `LSU_REGION_LIMIT_RST;
    m_en       = 1'b1;
    exp_bubble = 1'b1;
    exp_fault  = FAULT_NONE;
    exp_exc    = 32'd0;
    rstn = 1'b0;
    set_idle();
    apply_inputs();
    repeat (RESET_CYC) @(posedge clk);
    @(negedge clk);
    rstn = 1'b1;

    // Reset state, memory reads back zero
    repeat (N_ZERO)
    begin
      sz = pick_load_size();
      set_load(sz, align_addr($urandom_range(0, 1023), sz));
      step();
    end
    report_test("reset");

    // Stores then loads in the low 256 bytes
    repeat (N_STORE)
    begin
      sz = pick_store_size();
      set_store(sz, align_addr($urandom_range(0, 255), sz), $urandom);
      step();
      if ($urandom_range(0, 1) == 1)
        step();
    end
    repeat (N_LOAD)
    begin
      sz = pick_load_size();
      set_load(sz, align_addr($urandom_range(0, 255), sz));
      step();
      if ($urandom_range(0, 1) == 1)
        step();
    end
    report_test("round_trip");

    // No gaps between loads
    repeat (N_B2B)
    begin
      sz = pick_load_size();
      set_load(sz, align_addr($urandom_range(0, 255), sz));
      step();
    end
    report_test("back_to_back");

    // Odd offsets, then a word read of the same word
    repeat (N_MIS)
    begin
      base = {$urandom_range(0, 255), 2'b00} & 32'h3FC;
      if ($urandom_range(0, 1) == 1)
      begin
        sz   = ($urandom_range(0, 1) == 1) ? MS_H : MS_HU;
        addr = base + (($urandom_range(0, 1) == 1) ? 32'd3 : 32'd1);
      end
      else
      begin
        sz   = MS_W;
        addr = base + $urandom_range(1, 3);
      end
      if ($urandom_range(0, 1) == 1)
        set_store((sz == MS_HU) ? MS_H : sz, addr, $urandom);
      else
        set_load(sz, addr);
      step();
      set_load(MS_W, base);
      step();
    end
    report_test("misaligned");

    // Slots that must not issue
    repeat (N_SUP)
    begin
      sz = pick_load_size();
      set_load(sz, align_addr($urandom_range(0, 255), sz));
      case ($urandom_range(0, 3))
        0: n_bubble = 1'b1;
        1: n_exc = $urandom | 32'd1;
        2:
        begin
          n_stall = 1'b1;
          n_exc   = $urandom;
        end
        default: n_instr[6:0] = OPC7_ALU;
      endcase
      step();
    end
    report_test("suppress");

    // Window moves around, enable alternates
    for (int i = 0; i < N_REG; i++)
    begin
      base = $urandom_range(0, 32'h5FF);
      set_cfg(2'd0, base);
      step();
      set_cfg(2'd1, base + $urandom_range(0, 32'h200));
      step();
      set_cfg(2'd2, {$urandom_range(0, 32'h7FFF_FFFF), i[0]});
      step();
      // Unmapped address
      if (i % 4 == 0)
      begin
        set_cfg(2'd3, $urandom);
        step();
      end
      repeat (2)
      begin
        if ($urandom_range(0, 1) == 1)
        begin
          sz = pick_store_size();
          set_store(sz, align_addr($urandom_range(0, 32'h7FF), sz), $urandom);
        end
        else
        begin
          sz = pick_load_size();
          set_load(sz, align_addr($urandom_range(0, 32'h7FF), sz));
        end
        step();
      end
    end
    report_test("region");

    $display("Summary: %0d checks, %0d errors", checks, errors);
    if (errors == 0)
      $display("Testbench passed");
    else
      $display("Testbench failed");
    $finish;
  end

endmodule

`default_nettype wire

// ==== project.f ====
+incdir+hw
hw/lsu_pkg.sv
hw/lsu_region_regs.sv
hw/lsu_request.sv
hw/lsu_dmem.sv
hw/lsu_load_align.sv
hw/lsu_top.sv
verification/lsu_tb.sv

// ==== Makefile ====
# Verilator build of the LSU testbench

VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -Wno-fatal -j 0
TOP       := lsu_tb
FILELIST  := project.f
BUILD_DIR := obj_dir
LOG       := sim.log

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

# The run fails unless the log holds the pass line
run: compile
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "^Testbench passed$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
